//--- verilog/dram_gc_pkg.sv
// shared definitions for the DRAM global controller
// command field widths, queue depths and opcode values

package dram_gc_pkg;

    ////////////////////////////////////////
    // data and address fields
    ////////////////////////////////////////

    // one data word on every channel
    localparam int WORD_BITS  = 32;

    // DRAM address split
    localparam int ROW_BITS   = 12;
    localparam int COL_BITS   = 8;
    localparam int BANK_BITS  = 2;
    localparam int NUM_BANKS  = 2 ** BANK_BITS;

    // weights vs activations, passed through untouched
    localparam int DTYPE_BITS = 1;

    // queued command word, op in the top bit
    localparam int CMD_BITS   = 1 + DTYPE_BITS + ROW_BITS + COL_BITS + BANK_BITS;

    ////////////////////////////////////////
    // queue depths
    ////////////////////////////////////////

    // request and write-data queues share this depth
    localparam int REQ_FIFO_DEPTH   = 2;

    // max reads in flight across all banks
    localparam int READ_ORDER_DEPTH = 16;

    ////////////////////////////////////////
    // opcodes
    ////////////////////////////////////////

    localparam logic OP_READ  = 1'b0;
    localparam logic OP_WRITE = 1'b1;

endpackage

//--- verilog/sync_fifo.sv
// single-clock first-word-fall-through FIFO
// circular buffer with pointers and fill count

`timescale 1ns/100ps

module sync_fifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 4
) (
    input  logic             i_clk,
    input  logic             i_rst_n,
    input  logic             i_push,
    input  logic             i_pop,
    input  logic [WIDTH-1:0] i_data,
    output logic [WIDTH-1:0] o_data,
    output logic             o_empty,
    output logic             o_full
);

    localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_BITS = $clog2(DEPTH + 1);

    logic [WIDTH-1:0]    mem [DEPTH];
    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    logic [CNT_BITS-1:0] count;
    logic                do_push;
    logic                do_pop;

    // wrap at DEPTH, which need not be a power of two
    function automatic logic [PTR_BITS-1:0] next_ptr(input logic [PTR_BITS-1:0] ptr);
        if (ptr == PTR_BITS'(DEPTH - 1))
        begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign o_empty = (count == '0);
    assign o_full  = (count == CNT_BITS'(DEPTH));

    // pop on empty is dropped, full push allowed only with a pop
    assign do_pop  = i_pop && !o_empty;
    assign do_push = i_push && (!o_full || do_pop);

    // head word straight from storage
    assign o_data  = mem[rd_ptr];

    always_ff @(posedge i_clk)
    begin
        if (!i_rst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (do_push)
            begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_pop)
            begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            if (do_push && !do_pop)
            begin
                count <= count + 1'b1;
            end
            else if (do_pop && !do_push)
            begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (do_push)
        begin
            mem[wr_ptr] <= i_data;
        end
    end

    // producer holds off on full unless a slot frees up this cycle
    a_no_overflow : assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_push |-> (!o_full || i_pop));

endmodule

//--- verilog/request_queue.sv
// request channel handshake
// command queue and write-data queue

`timescale 1ns/100ps

module request_queue (
    input  logic                                i_clk,
    input  logic                                i_rst_n,
    input  logic                                i_cmd_valid,
    input  logic                                i_cmd_op,
    input  logic [dram_gc_pkg::DTYPE_BITS-1:0]  i_cmd_dtype,
    input  logic [dram_gc_pkg::ROW_BITS-1:0]    i_cmd_row,
    input  logic [dram_gc_pkg::COL_BITS-1:0]    i_cmd_col,
    input  logic [dram_gc_pkg::BANK_BITS-1:0]   i_cmd_bank,
    input  logic [dram_gc_pkg::WORD_BITS-1:0]   i_wr_data,
    input  logic                                i_dispatch,
    output logic                                o_ready,
    output logic                                o_head_valid,
    output logic                                o_head_op,
    output logic [dram_gc_pkg::DTYPE_BITS-1:0]  o_head_dtype,
    output logic [dram_gc_pkg::ROW_BITS-1:0]    o_head_row,
    output logic [dram_gc_pkg::COL_BITS-1:0]    o_head_col,
    output logic [dram_gc_pkg::BANK_BITS-1:0]   o_head_bank,
    output logic [dram_gc_pkg::WORD_BITS-1:0]   o_head_wr_data
);

    import dram_gc_pkg::*;

    logic                accept;
    logic                cmd_full;
    logic                cmd_empty;
    logic [CMD_BITS-1:0] cmd_in;
    logic [CMD_BITS-1:0] cmd_out;
    logic                wr_push;
    logic                wr_pop;

    ////////////////////////////////////////
    // request handshake
    ////////////////////////////////////////

    // a full queue still takes a request when the head leaves this cycle
    assign o_ready = !cmd_full || i_dispatch;
    assign accept  = i_cmd_valid && o_ready;

    // write data only queued for writes
    assign wr_push = accept && (i_cmd_op == OP_WRITE);
    assign wr_pop  = i_dispatch && (o_head_op == OP_WRITE);

    assign cmd_in = {i_cmd_op, i_cmd_dtype, i_cmd_row, i_cmd_col, i_cmd_bank};
    assign {o_head_op, o_head_dtype, o_head_row, o_head_col, o_head_bank} = cmd_out;
    assign o_head_valid = !cmd_empty;

    ////////////////////////////////////////
    // queues
    ////////////////////////////////////////

    sync_fifo #(
        .WIDTH (CMD_BITS),
        .DEPTH (REQ_FIFO_DEPTH)
    ) cmd_fifo_i (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_push  (accept),
        .i_pop   (i_dispatch),
        .i_data  (cmd_in),
        .o_data  (cmd_out),
        .o_empty (cmd_empty),
        .o_full  (cmd_full)
    );

    // never fuller than the command queue, so its flags go unused
    sync_fifo #(
        .WIDTH (WORD_BITS),
        .DEPTH (REQ_FIFO_DEPTH)
    ) wdata_fifo_i (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_push  (wr_push),
        .i_pop   (wr_pop),
        .i_data  (i_wr_data),
        .o_data  (o_head_wr_data),
        .o_empty (),
        .o_full  ()
    );

    // dispatcher only fires on a real head
    a_dispatch_has_head : assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_dispatch |-> o_head_valid);

endmodule

//--- verilog/bank_dispatch.sv
// routes the queue head onto its bank command channel
// flags a dispatch, and a read dispatch, on the handshake

`timescale 1ns/100ps

module bank_dispatch (
    input  logic                                i_head_valid,
    input  logic                                i_head_op,
    input  logic [dram_gc_pkg::DTYPE_BITS-1:0]  i_head_dtype,
    input  logic [dram_gc_pkg::ROW_BITS-1:0]    i_head_row,
    input  logic [dram_gc_pkg::COL_BITS-1:0]    i_head_col,
    input  logic [dram_gc_pkg::BANK_BITS-1:0]   i_head_bank,
    input  logic [dram_gc_pkg::WORD_BITS-1:0]   i_head_wr_data,
    input  logic                                i_bank_ready [dram_gc_pkg::NUM_BANKS],
    input  logic                                i_order_full,
    output logic                                o_bank_cmd_valid [dram_gc_pkg::NUM_BANKS],
    output logic                                o_bank_op [dram_gc_pkg::NUM_BANKS],
    output logic [dram_gc_pkg::DTYPE_BITS-1:0]  o_bank_dtype [dram_gc_pkg::NUM_BANKS],
    output logic [dram_gc_pkg::ROW_BITS-1:0]    o_bank_row [dram_gc_pkg::NUM_BANKS],
    output logic [dram_gc_pkg::COL_BITS-1:0]    o_bank_col [dram_gc_pkg::NUM_BANKS],
    output logic [dram_gc_pkg::WORD_BITS-1:0]   o_bank_wr_data [dram_gc_pkg::NUM_BANKS],
    output logic                                o_dispatch,
    output logic                                o_dispatch_read
);

    import dram_gc_pkg::*;

    logic [NUM_BANKS-1:0] valid_vec;

    // valid only toward the head's bank, and only once that bank is ready
    // a full read-order queue stalls writes as well
    always_comb
    begin
        for (int b = 0; b < NUM_BANKS; b++)
        begin
            valid_vec[b] = i_head_valid && !i_order_full && i_bank_ready[b]
                           && (i_head_bank == BANK_BITS'(b));

            o_bank_cmd_valid[b] = valid_vec[b];

            // fields shared by all banks
            o_bank_op[b]      = i_head_op;
            o_bank_dtype[b]   = i_head_dtype;
            o_bank_row[b]     = i_head_row;
            o_bank_col[b]     = i_head_col;
            o_bank_wr_data[b] = i_head_wr_data;
        end
    end

    // valid already carries the bank's ready, so any valid is a transfer
    assign o_dispatch      = |valid_vec;
    assign o_dispatch_read = o_dispatch && (i_head_op == OP_READ);

    always_comb
    begin
        a_one_bank : assert ($onehot0(valid_vec))
            else $error("more than one bank offered a command");
    end

endmodule

//--- verilog/read_order_tracker.sv
// read-order queue of issued read banks
// per-bank read enables and combinational return of read data

`timescale 1ns/100ps

module read_order_tracker (
    input  logic                               i_clk,
    input  logic                               i_rst_n,
    input  logic                               i_dispatch_read,
    input  logic [dram_gc_pkg::BANK_BITS-1:0]  i_head_bank,
    input  logic                               i_bank_rd_valid [dram_gc_pkg::NUM_BANKS],
    input  logic [dram_gc_pkg::WORD_BITS-1:0]  i_bank_rd_data [dram_gc_pkg::NUM_BANKS],
    output logic                               o_order_full,
    output logic                               o_bank_ren [dram_gc_pkg::NUM_BANKS],
    output logic                               o_rd_valid,
    output logic [dram_gc_pkg::WORD_BITS-1:0]  o_rd_data
);

    import dram_gc_pkg::*;

    logic [BANK_BITS-1:0] order_head;
    logic                 order_empty;
    logic [NUM_BANKS-1:0] ren_vec;
    logic [NUM_BANKS-1:0] rd_valid_vec;
    logic [NUM_BANKS-1:0] hs_vec;

    ////////////////////////////////////////
    // order queue
    ////////////////////////////////////////

    // one entry per read in flight, popped on its return
    sync_fifo #(
        .WIDTH (BANK_BITS),
        .DEPTH (READ_ORDER_DEPTH)
    ) order_fifo_i (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_push  (i_dispatch_read),
        .i_pop   (o_rd_valid),
        .i_data  (i_head_bank),
        .o_data  (order_head),
        .o_empty (order_empty),
        .o_full  (o_order_full)
    );

    ////////////////////////////////////////
    // return channel
    ////////////////////////////////////////

    // only the oldest read's bank may hand data back
    always_comb
    begin
        for (int b = 0; b < NUM_BANKS; b++)
        begin
            ren_vec[b]      = !order_empty && (order_head == BANK_BITS'(b));
            rd_valid_vec[b] = i_bank_rd_valid[b];
            hs_vec[b]       = ren_vec[b] && rd_valid_vec[b];
            o_bank_ren[b]   = ren_vec[b];
        end
    end

    // no back-pressure toward the requester
    assign o_rd_valid = |hs_vec;
    assign o_rd_data  = o_rd_valid ? i_bank_rd_data[order_head] : '0;

    // banks only answer reads this controller issued
    a_no_stray_return : assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (|rd_valid_vec) |-> !order_empty);

endmodule

//--- verilog/dram_global_controller.sv
// DRAM global controller top
// request queue, bank dispatch and read-order tracker

`timescale 1ns/100ps

module dram_global_controller (
    input  logic                                i_clk,
    input  logic                                i_rst_n,
    // request channel
    input  logic                                i_cmd_valid,
    input  logic                                i_cmd_op,
    input  logic [dram_gc_pkg::DTYPE_BITS-1:0]  i_cmd_dtype,
    input  logic [dram_gc_pkg::ROW_BITS-1:0]    i_cmd_row,
    input  logic [dram_gc_pkg::COL_BITS-1:0]    i_cmd_col,
    input  logic [dram_gc_pkg::BANK_BITS-1:0]   i_cmd_bank,
    input  logic [dram_gc_pkg::WORD_BITS-1:0]   i_wr_data,
    output logic                                o_ready,
    // bank command channels
    output logic                                o_bank_cmd_valid [dram_gc_pkg::NUM_BANKS],
    output logic                                o_bank_op [dram_gc_pkg::NUM_BANKS],
    output logic [dram_gc_pkg::DTYPE_BITS-1:0]  o_bank_dtype [dram_gc_pkg::NUM_BANKS],
    output logic [dram_gc_pkg::ROW_BITS-1:0]    o_bank_row [dram_gc_pkg::NUM_BANKS],
    output logic [dram_gc_pkg::COL_BITS-1:0]    o_bank_col [dram_gc_pkg::NUM_BANKS],
    output logic [dram_gc_pkg::WORD_BITS-1:0]   o_bank_wr_data [dram_gc_pkg::NUM_BANKS],
    input  logic                                i_bank_ready [dram_gc_pkg::NUM_BANKS],
    // bank return channels
    output logic                                o_bank_ren [dram_gc_pkg::NUM_BANKS],
    input  logic                                i_bank_rd_valid [dram_gc_pkg::NUM_BANKS],
    input  logic [dram_gc_pkg::WORD_BITS-1:0]   i_bank_rd_data [dram_gc_pkg::NUM_BANKS],
    // read data channel
    output logic                                o_rd_valid,
    output logic [dram_gc_pkg::WORD_BITS-1:0]   o_rd_data
);

    import dram_gc_pkg::*;

    // queue head
    logic                  head_valid;
    logic                  head_op;
    logic [DTYPE_BITS-1:0] head_dtype;
    logic [ROW_BITS-1:0]   head_row;
    logic [COL_BITS-1:0]   head_col;
    logic [BANK_BITS-1:0]  head_bank;
    logic [WORD_BITS-1:0]  head_wr_data;

    // dispatch status
    logic dispatch;
    logic dispatch_read;
    logic order_full;

    request_queue request_queue_i (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_cmd_valid    (i_cmd_valid),
        .i_cmd_op       (i_cmd_op),
        .i_cmd_dtype    (i_cmd_dtype),
        .i_cmd_row      (i_cmd_row),
        .i_cmd_col      (i_cmd_col),
        .i_cmd_bank     (i_cmd_bank),
        .i_wr_data      (i_wr_data),
        .i_dispatch     (dispatch),
        .o_ready        (o_ready),
        .o_head_valid   (head_valid),
        .o_head_op      (head_op),
        .o_head_dtype   (head_dtype),
        .o_head_row     (head_row),
        .o_head_col     (head_col),
        .o_head_bank    (head_bank),
        .o_head_wr_data (head_wr_data)
    );

    bank_dispatch bank_dispatch_i (
        .i_head_valid     (head_valid),
        .i_head_op        (head_op),
        .i_head_dtype     (head_dtype),
        .i_head_row       (head_row),
        .i_head_col       (head_col),
        .i_head_bank      (head_bank),
        .i_head_wr_data   (head_wr_data),
        .i_bank_ready     (i_bank_ready),
        .i_order_full     (order_full),
        .o_bank_cmd_valid (o_bank_cmd_valid),
        .o_bank_op        (o_bank_op),
        .o_bank_dtype     (o_bank_dtype),
        .o_bank_row       (o_bank_row),
        .o_bank_col       (o_bank_col),
        .o_bank_wr_data   (o_bank_wr_data),
        .o_dispatch       (dispatch),
        .o_dispatch_read  (dispatch_read)
    );

    read_order_tracker read_order_tracker_i (
        .i_clk           (i_clk),
        .i_rst_n         (i_rst_n),
        .i_dispatch_read (dispatch_read),
        .i_head_bank     (head_bank),
        .i_bank_rd_valid (i_bank_rd_valid),
        .i_bank_rd_data  (i_bank_rd_data),
        .o_order_full    (order_full),
        .o_bank_ren      (o_bank_ren),
        .o_rd_valid      (o_rd_valid),
        .o_rd_data       (o_rd_data)
    );

endmodule

//--- dv/bank_model.sv
// behavioural bank controller for the testbench
// random ready, write storage, delayed read return held until ren

`timescale 1ns/100ps

module bank_model #(
    parameter int          BANK = 0,
    parameter logic [31:0] SEED = 32'hb398_0656
) (
    input  logic                               i_clk,
    input  logic                               i_rst_n,
    input  logic                               i_stall,
    input  logic                               i_hold,
    input  logic                               i_cmd_valid,
    input  logic                               i_op,
    input  logic [dram_gc_pkg::ROW_BITS-1:0]   i_row,
    input  logic [dram_gc_pkg::COL_BITS-1:0]   i_col,
    input  logic [dram_gc_pkg::WORD_BITS-1:0]  i_wr_data,
    input  logic                               i_ren,
    output logic                               o_ready,
    output logic                               o_rd_valid,
    output logic [dram_gc_pkg::WORD_BITS-1:0]  o_rd_data
);

    import dram_gc_pkg::*;

    int                   seed = int'(SEED);
    logic [WORD_BITS-1:0] mem [logic [ROW_BITS+COL_BITS-1:0]];
    logic [WORD_BITS-1:0] pend_q [$];
    logic [2:0]           delay;

    // never-written locations read back a pattern of the full address
    function automatic logic [WORD_BITS-1:0] fill_word(input logic [ROW_BITS-1:0] row,
                                                       input logic [COL_BITS-1:0] col);
        return {8'hd5, 2'b00, BANK_BITS'(BANK), row, col};
    endfunction

    always @(posedge i_clk)
    begin
        if (!i_rst_n)
        begin
            o_ready    <= 1'b0;
            o_rd_valid <= 1'b0;
            o_rd_data  <= '0;
            delay      <= '0;
            pend_q.delete();
        end
        else
        begin
            // ready about three cycles in four
            o_ready <= !i_stall && (($random(seed) & 3) != 0);
            if (i_cmd_valid && o_ready)
            begin
                if (i_op == OP_WRITE)
                begin
                    mem[{i_row, i_col}] = i_wr_data;
                end
                else if (mem.exists({i_row, i_col}))
                begin
                    pend_q.push_back(mem[{i_row, i_col}]);
                end
                else
                begin
                    pend_q.push_back(fill_word(i_row, i_col));
                end
            end
            // valid and data stay up until the controller enables this bank
            if (o_rd_valid && i_ren)
            begin
                o_rd_valid <= 1'b0;
                delay      <= 3'($random(seed));
            end
            else if (!o_rd_valid && !i_hold && pend_q.size() != 0)
            begin
                if (delay == 3'd0)
                begin
                    o_rd_valid <= 1'b1;
                    o_rd_data  <= pend_q.pop_front();
                end
                else
                begin
                    delay <= delay - 1'b1;
                end
            end
        end
    end

endmodule

//--- dv/tb_dram_global_controller.sv
// testbench top for the DRAM global controller
// clock, reset, request stimulus, reference model, checkers, watchdog

`timescale 1ns/100ps

module tb_dram_global_controller;

    import dram_gc_pkg::*;

    localparam int NUM_TESTS     = 5;
    localparam int REQS_PER_TEST = 40;
    localparam int CLK_PERIOD    = 100;
    localparam int ADDR_BITS     = BANK_BITS + ROW_BITS + COL_BITS;
    localparam int REQ_BITS      = 1 + DTYPE_BITS + ADDR_BITS + WORD_BITS;

    logic                  clk;
    logic                  rst_n;
    logic                  cmd_valid;
    logic                  cmd_op;
    logic [DTYPE_BITS-1:0] cmd_dtype;
    logic [ROW_BITS-1:0]   cmd_row;
    logic [COL_BITS-1:0]   cmd_col;
    logic [BANK_BITS-1:0]  cmd_bank;
    logic [WORD_BITS-1:0]  wr_data;
    logic                  ready;
    logic                  bank_cmd_valid [NUM_BANKS];
    logic                  bank_op [NUM_BANKS];
    logic [DTYPE_BITS-1:0] bank_dtype [NUM_BANKS];
    logic [ROW_BITS-1:0]   bank_row [NUM_BANKS];
    logic [COL_BITS-1:0]   bank_col [NUM_BANKS];
    logic [WORD_BITS-1:0]  bank_wr_data [NUM_BANKS];
    logic                  bank_ready [NUM_BANKS];
    logic                  bank_ren [NUM_BANKS];
    logic                  bank_rd_valid [NUM_BANKS];
    logic [WORD_BITS-1:0]  bank_rd_data [NUM_BANKS];
    logic                  rd_valid;
    logic [WORD_BITS-1:0]  rd_data;
    logic                  stall;
    logic                  hold;

    // reference state, in request order
    logic [WORD_BITS-1:0] ref_mem [logic [ADDR_BITS-1:0]];
    logic [REQ_BITS-1:0]  sent_q [$];
    logic [WORD_BITS-1:0] exp_q [$];
    int seed;
    int errors = 0;
    int checks = 0;
    int accepted = 0;
    int dispatched = 0;
    int reads_issued = 0;
    int reads_returned = 0;

    dram_global_controller dut_i (
        .i_clk            (clk),
        .i_rst_n          (rst_n),
        .i_cmd_valid      (cmd_valid),
        .i_cmd_op         (cmd_op),
        .i_cmd_dtype      (cmd_dtype),
        .i_cmd_row        (cmd_row),
        .i_cmd_col        (cmd_col),
        .i_cmd_bank       (cmd_bank),
        .i_wr_data        (wr_data),
        .o_ready          (ready),
        .o_bank_cmd_valid (bank_cmd_valid),
        .o_bank_op        (bank_op),
        .o_bank_dtype     (bank_dtype),
        .o_bank_row       (bank_row),
        .o_bank_col       (bank_col),
        .o_bank_wr_data   (bank_wr_data),
        .i_bank_ready     (bank_ready),
        .o_bank_ren       (bank_ren),
        .i_bank_rd_valid  (bank_rd_valid),
        .i_bank_rd_data   (bank_rd_data),
        .o_rd_valid       (rd_valid),
        .o_rd_data        (rd_data)
    );

    for (genvar b = 0; b < NUM_BANKS; b++)
    begin : bank_gen
        bank_model #(
            .BANK (b),
            .SEED (32'hb398_0656 + b)
        ) bank_i (
            .i_clk       (clk),
            .i_rst_n     (rst_n),
            .i_stall     (stall),
            .i_hold      (hold),
            .i_cmd_valid (bank_cmd_valid[b]),
            .i_op        (bank_op[b]),
            .i_row       (bank_row[b]),
            .i_col       (bank_col[b]),
            .i_wr_data   (bank_wr_data[b]),
            .i_ren       (bank_ren[b]),
            .o_ready     (bank_ready[b]),
            .o_rd_valid  (bank_rd_valid[b]),
            .o_rd_data   (bank_rd_data[b])
        );
    end

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    ////////////////////////////////////////
    // reference model and checkers
    ////////////////////////////////////////

    // last word written to the location, else the address fill pattern
    function automatic logic [WORD_BITS-1:0] expected_read(input logic [BANK_BITS-1:0] bank,
                                                           input logic [ROW_BITS-1:0] row,
                                                           input logic [COL_BITS-1:0] col);
        if (ref_mem.exists({bank, row, col}))
        begin
            return ref_mem[{bank, row, col}];
        end
        return {8'hd5, 2'b00, bank, row, col};
    endfunction

    always @(posedge clk)
    begin
        if (rst_n && cmd_valid && ready)
        begin
            accepted++;
            sent_q.push_back({cmd_op, cmd_dtype, cmd_row, cmd_col, cmd_bank, wr_data});
            if (cmd_op == OP_WRITE)
            begin
                ref_mem[{cmd_bank, cmd_row, cmd_col}] = wr_data;
            end
            else
            begin
                exp_q.push_back(expected_read(cmd_bank, cmd_row, cmd_col));
            end
        end
    end

    // each dispatch must match the oldest accepted request
    always @(posedge clk)
    begin : dispatch_check
        logic [REQ_BITS-1:0] want;
        logic [REQ_BITS-1:0] got;
        for (int b = 0; b < NUM_BANKS; b++)
        begin
            if (rst_n && bank_cmd_valid[b] && bank_ready[b])
            begin
                checks++;
                dispatched++;
                got = {bank_op[b], bank_dtype[b], bank_row[b], bank_col[b],
                       BANK_BITS'(b), bank_wr_data[b]};
                assert (sent_q.size() != 0)
                else
                begin
                    $display("bank %0d took a command that was never accepted", b);
                    errors++;
                end
                if (sent_q.size() != 0)
                begin
                    want = sent_q.pop_front();
                    // no write data on a read
                    if (want[REQ_BITS-1] == OP_READ)
                    begin
                        got[WORD_BITS-1:0] = want[WORD_BITS-1:0];
                    end
                    assert (got == want)
                    else
                    begin
                        $display("ERROR %0t: bank %0d command %h, expected %h",
                                 $time, b, got, want);
                        errors++;
                    end
                end
                if (bank_op[b] == OP_READ)
                begin
                    reads_issued++;
                end
                assert (reads_issued - reads_returned <= READ_ORDER_DEPTH)
                else
                begin
                    $display("ERROR %0t: %0d reads outstanding",
                             $time, reads_issued - reads_returned);
                    errors++;
                end
            end
        end
    end

    always @(posedge clk)
    begin : read_compare
        logic [WORD_BITS-1:0] exp_word;
        if (rst_n && rd_valid)
        begin
            checks++;
            reads_returned++;
            assert (exp_q.size() != 0)
            else
            begin
                $display("read data returned with no read outstanding");
                errors++;
            end
            if (exp_q.size() != 0)
            begin
                exp_word = exp_q.pop_front();
                assert (rd_data == exp_word)
                else
                begin
                    $display("ERROR %0t: read data %h, expected %h", $time, rd_data, exp_word);
                    errors++;
                end
            end
        end
    end

    ////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////

    task automatic send_random(input int count, input int read_eighths,
                               input logic [ROW_BITS-1:0] row_mask,
                               input logic [COL_BITS-1:0] col_mask);
        for (int i = 0; i < count; i++)
        begin
            cmd_valid <= 1'b1;
            cmd_op    <= (($random(seed) & 7) < read_eighths) ? OP_READ : OP_WRITE;
            cmd_dtype <= DTYPE_BITS'($random(seed));
            cmd_row   <= ROW_BITS'($random(seed)) & row_mask;
            cmd_col   <= COL_BITS'($random(seed)) & col_mask;
            cmd_bank  <= BANK_BITS'($random(seed));
            wr_data   <= $random(seed);
            @(posedge clk);
            while (!ready)
            begin
                @(posedge clk);
            end
        end
        cmd_valid <= 1'b0;
    endtask

    // until every accepted request is dispatched and every read returned
    task automatic wait_drain();
        @(posedge clk);
        while (sent_q.size() != 0 || exp_q.size() != 0)
        begin
            @(posedge clk);
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        $display("test %s done, %0d errors", name, errors - errs_before);
    endtask

    function automatic logic banks_idle();
        for (int b = 0; b < NUM_BANKS; b++)
        begin
            if (bank_cmd_valid[b] || bank_ren[b])
            begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    initial
    begin : stimulus
        int mark;
        int base;
        int disp_base;
        seed      = 32'hb398_0656;
        rst_n     <= 1'b0;
        cmd_valid <= 1'b0;
        cmd_op    <= OP_READ;
        cmd_dtype <= '0;
        cmd_row   <= '0;
        cmd_col   <= '0;
        cmd_bank  <= '0;
        wr_data   <= '0;
        stall     <= 1'b0;
        hold      <= 1'b0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;

        mark = errors;
        @(posedge clk);
        checks++;
        assert (ready && !rd_valid && banks_idle())
        else
        begin
            $display("ERROR %0t: outputs not idle after reset", $time);
            errors++;
        end
        report_test("reset state", mark);

        mark = errors;
        send_random(REQS_PER_TEST, 3, '1, '1);
        wait_drain();
        report_test("routing", mark);

        // few addresses, so most reads hit earlier writes
        mark = errors;
        send_random(REQS_PER_TEST, 5, 12'h003, 8'h03);
        wait_drain();
        report_test("read order", mark);

        mark = errors;
        stall <= 1'b1;
        repeat (2) @(posedge clk);
        base      = accepted;
        disp_base = dispatched;
        fork
            send_random(REQ_FIFO_DEPTH + 2, 4, '1, '1);
            begin
                repeat (20) @(posedge clk);
                checks++;
                assert (accepted - base == REQ_FIFO_DEPTH && !ready)
                else
                begin
                    $display("ERROR %0t: %0d requests taken while stalled", $time, accepted - base);
                    errors++;
                end
                stall <= 1'b0;
            end
        join
        wait_drain();
        // every accepted request leaves exactly once
        checks++;
        assert (dispatched - disp_base == REQ_FIFO_DEPTH + 2)
        else
        begin
            $display("ERROR %0t: %0d commands dispatched in total", $time, dispatched - disp_base);
            errors++;
        end
        report_test("back-pressure", mark);

        mark = errors;
        hold <= 1'b1;
        base = reads_issued;
        fork
            send_random(READ_ORDER_DEPTH + 4, 8, '1, '1);
            begin
                repeat (150) @(posedge clk);
                checks++;
                assert (reads_issued - base == READ_ORDER_DEPTH)
                else
                begin
                    $display("ERROR %0t: %0d reads issued", $time, reads_issued - base);
                    errors++;
                end
                hold <= 1'b0;
            end
        join
        wait_drain();
        report_test("read limit", mark);

        $display("tests %0d, checks %0d, errors %0d", NUM_TESTS, checks, errors);
        if (errors == 0)
        begin
            $display("ALL CHECKS PASSED");
        end
        else
        begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    initial
    begin
        repeat (NUM_TESTS * REQS_PER_TEST * 50) @(posedge clk);
        $display("watchdog expired before all tests finished");
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

//--- tb.f
verilog/dram_gc_pkg.sv
verilog/sync_fifo.sv
verilog/request_queue.sv
verilog/bank_dispatch.sv
verilog/read_order_tracker.sv
verilog/dram_global_controller.sv
dv/bank_model.sv
dv/tb_dram_global_controller.sv

//--- Makefile
# Verilator flow for the DRAM global controller testbench

TOP := tb_dram_global_controller

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall -Wno-fatal --timing --top-module $(TOP) -f tb.f

# pass only when the log holds the pass line
sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f tb.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "ALL CHECKS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
